// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = lsq_tb
FILELIST  = sim.f

.PHONY: all compile run clean

all: run

# Build the simulation binary into obj_dir
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the pass message shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

// ==== sim.f ====
verilog/lsq_pkg.sv
verilog/store_queue.sv
verilog/load_buffer.sv
verilog/store_forward.sv
verilog/load_store_queue.sv
tests/lsq_tb.sv

// ==== tests/lsq_tb.sv ====
`timescale 1ns/1ps

module lsq_tb import lsq_pkg::*; ();

    typedef enum logic [2:0] {
        OP_IDLE,
        OP_ST_ALLOC,
        OP_ST_RESOLVE,
        OP_LD_ALLOC,
        OP_LD_RESOLVE,
        OP_COMMIT
    } op_t;

    // One table row is one clock cycle of stimulus
    typedef struct packed {
        op_t   op;
        int    idx;
        addr_t addr;
        data_t data;
        tag_t  tag;
    } row_t;

    typedef struct packed {
        logic        fwd;
        logic [31:0] value;
        tag_t        tag;
    } result_t;

    logic    clock;
    logic    reset;
    logic    sq_alloc;
    logic    sq_resolve_valid;
    sq_idx_t sq_resolve_idx;
    addr_t   sq_resolve_addr;
    data_t   sq_resolve_data;
    logic    store_commit;
    logic    lb_alloc;
    logic    lb_resolve_valid;
    lb_idx_t lb_resolve_idx;
    addr_t   lb_resolve_addr;
    tag_t    lb_resolve_tag;

    logic    sq_full;
    sq_idx_t sq_tail;
    logic    sq_head_resolved;
    logic    lb_full;
    lb_idx_t lb_alloc_idx;
    logic    store_cache_valid;
    addr_t   store_cache_addr;
    data_t   store_cache_data;
    logic    load_cache_valid;
    addr_t   load_cache_addr;
    tag_t    load_cache_tag;
    logic    fwd_valid;
    data_t   fwd_data;
    tag_t    fwd_tag;

    row_t    rows[$];
    result_t exp_q[$];
    int      seed = 32'ha1cb;
    int      cycle_count = 0;
    int      cycle_limit = 0;

    // Reference model state
    int      ref_head;
    int      ref_tail;
    int      ref_count;
    logic    st_busy [SQ_DEPTH];
    logic    st_res  [SQ_DEPTH];
    addr_t   st_addr [SQ_DEPTH];
    data_t   st_data [SQ_DEPTH];
    logic    ld_busy [LB_DEPTH];
    logic    ld_res  [LB_DEPTH];
    int      ld_age  [LB_DEPTH];
    addr_t   ld_addr [LB_DEPTH];
    tag_t    ld_tag  [LB_DEPTH];

    load_store_queue dut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    //////////////////////////////////////////////////
    // Checking helpers
    //////////////////////////////////////////////////

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic int lowest_free_load();
        int slot;

        slot = LB_DEPTH;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (!ld_busy[j]) slot = j;
        end
        return slot;
    endfunction

    // Stores older than a load occupy head up to its age
    function automatic logic older_stores_resolved(input int age);
        int   n;
        logic ok;

        ok = 1'b1;
        n  = (age - ref_head + SQ_DEPTH) % SQ_DEPTH;
        for (int k = 0; k < n; k++) begin
            if (!st_res[(ref_head + k) % SQ_DEPTH]) ok = 1'b0;
        end
        return ok;
    endfunction

    function automatic int youngest_match(input int age, input addr_t addr);
        int n;
        int s;
        int hit;

        hit = -1;
        n   = (age - ref_head + SQ_DEPTH) % SQ_DEPTH;
        for (int k = 0; k < n; k++) begin
            s = (ref_head + k) % SQ_DEPTH;
            if (st_addr[s] == addr) hit = s;
        end
        return hit;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    task automatic reset_model();
        ref_head  = 0;
        ref_tail  = 0;
        ref_count = 0;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            st_busy[k] = 1'b0;
            st_res[k]  = 1'b0;
        end
        for (int j = 0; j < LB_DEPTH; j++) begin
            ld_busy[j] = 1'b0;
            ld_res[j]  = 1'b0;
        end
    endtask

    // Applies one clock edge with the row that was driven before it
    task automatic step_model(input row_t r);
        int      pick;
        int      slot;
        int      hit;
        logic    retire;
        result_t e;

        // Issue choice uses the state before the edge
        pick = -1;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (ld_busy[j] && ld_res[j] && older_stores_resolved(ld_age[j])) pick = j;
        end
        retire = (r.op == OP_COMMIT) && st_busy[ref_head] && st_res[ref_head];

        case (r.op)
            OP_ST_ALLOC: begin
                st_busy[ref_tail] = 1'b1;
                st_res[ref_tail]  = 1'b0;
                ref_tail  = (ref_tail + 1) % SQ_DEPTH;
                ref_count = ref_count + 1;
            end
            OP_ST_RESOLVE: begin
                st_res[r.idx]  = 1'b1;
                st_addr[r.idx] = r.addr;
                st_data[r.idx] = r.data;
            end
            OP_LD_ALLOC: begin
                slot = lowest_free_load();
                ld_busy[slot] = 1'b1;
                ld_res[slot]  = 1'b0;
                ld_age[slot]  = ref_tail;
            end
            OP_LD_RESOLVE: begin
                ld_res[r.idx]  = 1'b1;
                ld_addr[r.idx] = r.addr;
                ld_tag[r.idx]  = r.tag;
            end
            default: ;
        endcase

        if (retire) begin
            st_busy[ref_head] = 1'b0;
            st_res[ref_head]  = 1'b0;
            ref_head  = (ref_head + 1) % SQ_DEPTH;
            ref_count = ref_count - 1;
        end

        // Store retired at this edge is already out of the search range
        if (pick >= 0) begin
            hit   = youngest_match(ld_age[pick], ld_addr[pick]);
            e.fwd = (hit >= 0);
            e.tag = ld_tag[pick];
            if (hit >= 0) e.value = st_data[hit];
            else e.value = ld_addr[pick];
            exp_q.push_back(e);
            ld_busy[pick] = 1'b0;
            ld_res[pick]  = 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic add_row(input op_t op, input int idx, input addr_t addr,
                           input data_t data, input tag_t tag);
        row_t r;

        r.op   = op;
        r.idx  = idx;
        r.addr = addr;
        r.data = data;
        r.tag  = tag;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(OP_IDLE, 0, '0, '0, '0);
        // Fill store queue, then commit with an unresolved head
        repeat (SQ_DEPTH - 1) add_row(OP_ST_ALLOC, 0, '0, '0, '0);
        add_row(OP_COMMIT, 0, '0, '0, '0);
        add_row(OP_ST_RESOLVE, 0, 32'h0000_0040, $random(seed), '0);
        add_row(OP_ST_RESOLVE, 1, 32'h0000_0080, $random(seed), '0);
        repeat (3) add_row(OP_COMMIT, 0, '0, '0, '0);

        // Load 0 waits behind stores 2..6, store 7 is younger
        add_row(OP_LD_ALLOC, 0, '0, '0, '0);
        add_row(OP_LD_RESOLVE, 0, 32'h0000_0100, '0, 6'd5);
        add_row(OP_ST_ALLOC, 0, '0, '0, '0);
        add_row(OP_ST_RESOLVE, 7, 32'h0000_0100, $random(seed), '0);
        repeat (3) add_row(OP_LD_ALLOC, 0, '0, '0, '0);
        add_row(OP_LD_RESOLVE, 1, addr_t'($random(seed)) & 32'hffff_fffc, '0, 6'd9);
        add_row(OP_LD_RESOLVE, 2, 32'h0000_0300, '0, 6'd12);
        add_row(OP_LD_RESOLVE, 3, 32'h0000_0500, '0, 6'd13);

        // Two older stores to 0x100, the younger one must forward
        add_row(OP_ST_RESOLVE, 2, 32'h0000_0100, $random(seed), '0);
        add_row(OP_ST_RESOLVE, 3, 32'h0000_0200, $random(seed), '0);
        add_row(OP_ST_RESOLVE, 4, 32'h0000_0100, $random(seed), '0);
        add_row(OP_ST_RESOLVE, 5, 32'h0000_0300, $random(seed), '0);
        add_row(OP_ST_RESOLVE, 6, addr_t'($random(seed)) & 32'hffff_fffc,
                $random(seed), '0);
        repeat (2) add_row(OP_IDLE, 0, '0, '0, '0);
        repeat (7) add_row(OP_COMMIT, 0, '0, '0, '0);

        // Wrapped queue, younger unresolved store does not block
        add_row(OP_ST_ALLOC, 0, '0, '0, '0);
        add_row(OP_LD_ALLOC, 0, '0, '0, '0);
        add_row(OP_LD_RESOLVE, 0, 32'h0000_0700, '0, 6'd20);
        add_row(OP_ST_ALLOC, 0, '0, '0, '0);
        add_row(OP_ST_RESOLVE, 0, 32'h0000_0700, $random(seed), '0);
        add_row(OP_IDLE, 0, '0, '0, '0);
        add_row(OP_ST_RESOLVE, 1, addr_t'($random(seed)) & 32'hffff_fffc,
                $random(seed), '0);
        repeat (2) add_row(OP_COMMIT, 0, '0, '0, '0);
        repeat (3) add_row(OP_IDLE, 0, '0, '0, '0);
    endtask

    task automatic drive_row(input row_t r);
        sq_alloc         = (r.op == OP_ST_ALLOC);
        sq_resolve_valid = (r.op == OP_ST_RESOLVE);
        sq_resolve_idx   = sq_idx_t'(r.idx);
        sq_resolve_addr  = r.addr;
        sq_resolve_data  = r.data;
        store_commit     = (r.op == OP_COMMIT);
        lb_alloc         = (r.op == OP_LD_ALLOC);
        lb_resolve_valid = (r.op == OP_LD_RESOLVE);
        lb_resolve_idx   = lb_idx_t'(r.idx);
        lb_resolve_addr  = r.addr;
        lb_resolve_tag   = r.tag;
    endtask

    // Outputs are compared mid-cycle, after the inputs have settled
    task automatic check_cycle(input row_t r);
        int      free_slot;
        logic    exp_retire;
        result_t e;

        free_slot  = lowest_free_load();
        exp_retire = (r.op == OP_COMMIT) && st_busy[ref_head] && st_res[ref_head];
        check_value("sq_tail", 32'(sq_tail), 32'(ref_tail));
        check_value("sq_full", 32'(sq_full), 32'(ref_count == SQ_DEPTH - 1));
        check_value("sq_head_resolved", 32'(sq_head_resolved),
                    32'(st_busy[ref_head] && st_res[ref_head]));
        check_value("lb_full", 32'(lb_full), 32'(free_slot == LB_DEPTH));
        if (free_slot < LB_DEPTH) begin
            check_value("lb_alloc_idx", 32'(lb_alloc_idx), 32'(free_slot));
        end
        check_value("store_cache_valid", 32'(store_cache_valid), 32'(exp_retire));
        if (exp_retire) begin
            check_value("store_cache_addr", store_cache_addr, st_addr[ref_head]);
            check_value("store_cache_data", store_cache_data, st_data[ref_head]);
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            check_value("fwd_valid", 32'(fwd_valid), 32'(e.fwd));
            check_value("load_cache_valid", 32'(load_cache_valid), 32'(!e.fwd));
            if (e.fwd) begin
                check_value("fwd_data", fwd_data, e.value);
                check_value("fwd_tag", 32'(fwd_tag), 32'(e.tag));
            end else begin
                check_value("load_cache_addr", load_cache_addr, e.value);
                check_value("load_cache_tag", 32'(load_cache_tag), 32'(e.tag));
            end
        end else begin
            check_value("fwd_valid", 32'(fwd_valid), 32'd0);
            check_value("load_cache_valid", 32'(load_cache_valid), 32'd0);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        drive_row('0);
        build_table();
        reset_model();
        cycle_limit = rows.size() + 20;

        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        foreach (rows[i]) begin
            drive_row(rows[i]);
            @(negedge clock);
            check_cycle(rows[i]);
            @(posedge clock);
            #1;
            step_model(rows[i]);
        end

        if (exp_q.size() > 0) begin
            $display("Run ended with %0d issued loads that never produced a result",
                     exp_q.size());
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== verilog/load_buffer.sv ====
`timescale 1ns/1ps

module load_buffer import lsq_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    input  logic    lb_alloc,
    input  logic    lb_resolve_valid,
    input  lb_idx_t lb_resolve_idx,
    input  addr_t   lb_resolve_addr,
    input  tag_t    lb_resolve_tag,

    input  sq_idx_t sq_head,
    input  sq_idx_t sq_tail,
    input  sq_idx_t oldest_unresolved,
    input  logic    all_resolved,

    output logic    lb_full,
    output lb_idx_t lb_alloc_idx,

    output logic    issue_valid,
    output addr_t   issue_addr,
    output sq_idx_t issue_age,
    output tag_t    issue_tag
);

    logic [LB_DEPTH-1:0] lb_busy;
    logic [LB_DEPTH-1:0] lb_resolved;
    logic [LB_DEPTH-1:0] issuable;
    sq_idx_t             lb_age  [LB_DEPTH];
    addr_t               lb_addr [LB_DEPTH];
    tag_t                lb_tag  [LB_DEPTH];

    logic                issue_found;
    lb_idx_t             issue_idx;

    //////////////////////////////////////////////////
    // Free slot choice
    //////////////////////////////////////////////////

    assign lb_full = &lb_busy;

    // Downward walk leaves the lowest free slot
    always_comb begin
        lb_alloc_idx = '0;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (!lb_busy[j]) begin
                lb_alloc_idx = lb_idx_t'(j);
            end
        end
    end

    //////////////////////////////////////////////////
    // Issue rule
    //////////////////////////////////////////////////

    // Distances are taken from the head, so wrap-around needs no special case
    always_comb begin
        sq_idx_t age_dist;
        sq_idx_t safe_dist;

        safe_dist = oldest_unresolved - sq_head;
        for (int j = 0; j < LB_DEPTH; j++) begin
            age_dist    = lb_age[j] - sq_head;
            issuable[j] = lb_busy[j] && lb_resolved[j] &&
                          (all_resolved || age_dist <= safe_dist);
        end
    end

    // Lowest issuable slot wins
    always_comb begin
        issue_found = 1'b0;
        issue_idx   = '0;
        for (int j = LB_DEPTH - 1; j >= 0; j--) begin
            if (issuable[j]) begin
                issue_found = 1'b1;
                issue_idx   = lb_idx_t'(j);
            end
        end
    end

    //////////////////////////////////////////////////
    // Slot state and issue register
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            lb_busy     <= '0;
            lb_resolved <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (lb_alloc) begin
                lb_busy[lb_alloc_idx]     <= 1'b1;
                lb_resolved[lb_alloc_idx] <= 1'b0;
            end

            if (lb_resolve_valid) begin
                lb_resolved[lb_resolve_idx] <= 1'b1;
            end

            // Issued slot is freed as it moves into the issue register
            if (issue_found) begin
                lb_busy[issue_idx]     <= 1'b0;
                lb_resolved[issue_idx] <= 1'b0;
            end
            issue_valid <= issue_found;
        end
    end

    always_ff @(posedge clock) begin
        // Age is the store tail seen at allocation
        if (lb_alloc) begin
            lb_age[lb_alloc_idx] <= sq_tail;
        end
        if (lb_resolve_valid) begin
            lb_addr[lb_resolve_idx] <= lb_resolve_addr;
            lb_tag[lb_resolve_idx]  <= lb_resolve_tag;
        end
        if (issue_found) begin
            issue_addr <= lb_addr[issue_idx];
            issue_age  <= lb_age[issue_idx];
            issue_tag  <= lb_tag[issue_idx];
        end
    end

    //////////////////////////////////////////////////
    // Environment checks
    //////////////////////////////////////////////////

    alloc_not_full: assert property (
        @(posedge clock) disable iff (reset)
        lb_alloc |-> !lb_full
    ) else $error("load allocated into a full buffer");

    resolve_busy_slot: assert property (
        @(posedge clock) disable iff (reset)
        lb_resolve_valid |-> lb_busy[lb_resolve_idx] && !lb_resolved[lb_resolve_idx]
    ) else $error("load resolve names a free or resolved slot");

endmodule

// ==== verilog/load_store_queue.sv ====
`timescale 1ns/1ps

module load_store_queue import lsq_pkg::*; (
    input  logic    clock,
    input  logic    reset,

    // Store side
    input  logic    sq_alloc,
    input  logic    sq_resolve_valid,
    input  sq_idx_t sq_resolve_idx,
    input  addr_t   sq_resolve_addr,
    input  data_t   sq_resolve_data,
    input  logic    store_commit,

    // Load side
    input  logic    lb_alloc,
    input  logic    lb_resolve_valid,
    input  lb_idx_t lb_resolve_idx,
    input  addr_t   lb_resolve_addr,
    input  tag_t    lb_resolve_tag,

    output logic    sq_full,
    output sq_idx_t sq_tail,
    output logic    sq_head_resolved,
    output logic    lb_full,
    output lb_idx_t lb_alloc_idx,

    // Data cache
    output logic    store_cache_valid,
    output addr_t   store_cache_addr,
    output data_t   store_cache_data,
    output logic    load_cache_valid,
    output addr_t   load_cache_addr,
    output tag_t    load_cache_tag,

    // Result bus
    output logic    fwd_valid,
    output data_t   fwd_data,
    output tag_t    fwd_tag
);

    sq_idx_t               sq_head;
    sq_idx_t               oldest_unresolved;
    logic                  all_resolved;
    addr_t [SQ_DEPTH-1:0]  sq_entry_addr;
    data_t [SQ_DEPTH-1:0]  sq_entry_data;

    logic                  issue_valid;
    addr_t                 issue_addr;
    sq_idx_t               issue_age;
    tag_t                  issue_tag;

    store_queue u_store_queue (
        .clock             (clock),
        .reset             (reset),
        .sq_alloc          (sq_alloc),
        .sq_resolve_valid  (sq_resolve_valid),
        .sq_resolve_idx    (sq_resolve_idx),
        .sq_resolve_addr   (sq_resolve_addr),
        .sq_resolve_data   (sq_resolve_data),
        .store_commit      (store_commit),
        .sq_full           (sq_full),
        .sq_tail           (sq_tail),
        .sq_head           (sq_head),
        .sq_head_resolved  (sq_head_resolved),
        .oldest_unresolved (oldest_unresolved),
        .all_resolved      (all_resolved),
        .sq_entry_addr     (sq_entry_addr),
        .sq_entry_data     (sq_entry_data),
        .store_cache_valid (store_cache_valid),
        .store_cache_addr  (store_cache_addr),
        .store_cache_data  (store_cache_data)
    );

    load_buffer u_load_buffer (
        .clock             (clock),
        .reset             (reset),
        .lb_alloc          (lb_alloc),
        .lb_resolve_valid  (lb_resolve_valid),
        .lb_resolve_idx    (lb_resolve_idx),
        .lb_resolve_addr   (lb_resolve_addr),
        .lb_resolve_tag    (lb_resolve_tag),
        .sq_head           (sq_head),
        .sq_tail           (sq_tail),
        .oldest_unresolved (oldest_unresolved),
        .all_resolved      (all_resolved),
        .lb_full           (lb_full),
        .lb_alloc_idx      (lb_alloc_idx),
        .issue_valid       (issue_valid),
        .issue_addr        (issue_addr),
        .issue_age         (issue_age),
        .issue_tag         (issue_tag)
    );

    store_forward u_store_forward (
        .issue_valid       (issue_valid),
        .issue_addr        (issue_addr),
        .issue_age         (issue_age),
        .issue_tag         (issue_tag),
        .sq_head           (sq_head),
        .sq_entry_addr     (sq_entry_addr),
        .sq_entry_data     (sq_entry_data),
        .fwd_valid         (fwd_valid),
        .fwd_data          (fwd_data),
        .fwd_tag           (fwd_tag),
        .load_cache_valid  (load_cache_valid),
        .load_cache_addr   (load_cache_addr),
        .load_cache_tag    (load_cache_tag)
    );

endmodule

// ==== verilog/lsq_pkg.sv ====
package lsq_pkg;

    //////////////////////////////////////////////////
    // Queue sizes
    //////////////////////////////////////////////////

    // One slot stays empty so the tail never meets the head
    localparam int SQ_DEPTH = 8;
    localparam int SQ_IDX_W = 3;

    localparam int LB_DEPTH = 4;
    localparam int LB_IDX_W = 2;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int TAG_W  = 6;

    // Store queue index, also used as load age
    typedef logic [SQ_IDX_W-1:0] sq_idx_t;
    typedef logic [LB_IDX_W-1:0] lb_idx_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [TAG_W-1:0]    tag_t;

endpackage

// ==== verilog/store_forward.sv ====
`timescale 1ns/1ps

module store_forward import lsq_pkg::*; (
    input  logic                  issue_valid,
    input  addr_t                 issue_addr,
    input  sq_idx_t               issue_age,
    input  tag_t                  issue_tag,

    input  sq_idx_t               sq_head,
    input  addr_t [SQ_DEPTH-1:0]  sq_entry_addr,
    input  data_t [SQ_DEPTH-1:0]  sq_entry_data,

    output logic                  fwd_valid,
    output data_t                 fwd_data,
    output tag_t                  fwd_tag,

    output logic                  load_cache_valid,
    output addr_t                 load_cache_addr,
    output tag_t                  load_cache_tag
);

    logic    hit;
    sq_idx_t hit_idx;

    //////////////////////////////////////////////////
    // Older store search
    //////////////////////////////////////////////////

    // Stores older than the load sit in [head, age)
    // Later matches are younger, so they overwrite earlier ones
    always_comb begin
        sq_idx_t older_cnt;
        sq_idx_t idx;

        older_cnt = issue_age - sq_head;
        hit       = 1'b0;
        hit_idx   = sq_head;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            idx = sq_head + sq_idx_t'(k);
            if (sq_idx_t'(k) < older_cnt && sq_entry_addr[idx] == issue_addr) begin
                hit     = 1'b1;
                hit_idx = idx;
            end
        end
    end

    //////////////////////////////////////////////////
    // Result bus or cache read
    //////////////////////////////////////////////////

    assign fwd_valid = issue_valid && hit;
    assign fwd_data  = sq_entry_data[hit_idx];
    assign fwd_tag   = issue_tag;

    // Words are aligned, so a miss means no overlap at all
    assign load_cache_valid = issue_valid && !hit;
    assign load_cache_addr  = issue_addr;
    assign load_cache_tag   = issue_tag;

endmodule

// ==== verilog/store_queue.sv ====
`timescale 1ns/1ps

module store_queue import lsq_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,

    input  logic                     sq_alloc,
    input  logic                     sq_resolve_valid,
    input  sq_idx_t                  sq_resolve_idx,
    input  addr_t                    sq_resolve_addr,
    input  data_t                    sq_resolve_data,
    input  logic                     store_commit,

    output logic                     sq_full,
    output sq_idx_t                  sq_tail,
    output sq_idx_t                  sq_head,
    output logic                     sq_head_resolved,
    output sq_idx_t                  oldest_unresolved,
    output logic                     all_resolved,

    output addr_t [SQ_DEPTH-1:0]     sq_entry_addr,
    output data_t [SQ_DEPTH-1:0]     sq_entry_data,

    output logic                     store_cache_valid,
    output addr_t                    store_cache_addr,
    output data_t                    store_cache_data
);

    logic [SQ_DEPTH-1:0] sq_busy;
    logic [SQ_DEPTH-1:0] sq_resolved;
    sq_idx_t             sq_count;
    logic                retire;

    //////////////////////////////////////////////////
    // Head status and retire
    //////////////////////////////////////////////////

    assign sq_full          = (sq_count == sq_idx_t'(SQ_DEPTH - 1));
    assign sq_head_resolved = sq_busy[sq_head] && sq_resolved[sq_head];

    // Commit of an empty or unresolved head is dropped
    assign retire = store_commit && sq_head_resolved;

    // Cache write goes out in the commit cycle itself
    assign store_cache_valid = retire;
    assign store_cache_addr  = sq_entry_addr[sq_head];
    assign store_cache_data  = sq_entry_data[sq_head];

    //////////////////////////////////////////////////
    // Oldest unresolved store
    //////////////////////////////////////////////////

    // Walk from youngest to oldest so the oldest hit is kept last
    always_comb begin
        sq_idx_t idx;

        oldest_unresolved = sq_tail;
        all_resolved      = 1'b1;
        for (int k = SQ_DEPTH - 1; k >= 0; k--) begin
            idx = sq_head + sq_idx_t'(k);
            if (sq_idx_t'(k) < sq_count && !sq_resolved[idx]) begin
                oldest_unresolved = idx;
                all_resolved      = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Pointers and slot state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_head     <= '0;
            sq_tail     <= '0;
            sq_count    <= '0;
            sq_busy     <= '0;
            sq_resolved <= '0;
        end else begin
            if (sq_alloc) begin
                sq_busy[sq_tail]     <= 1'b1;
                sq_resolved[sq_tail] <= 1'b0;
                sq_tail              <= sq_tail + 1'b1;
            end

            if (sq_resolve_valid) begin
                sq_resolved[sq_resolve_idx] <= 1'b1;
            end

            // Tail and head never coincide while a retire is possible
            if (retire) begin
                sq_busy[sq_head]     <= 1'b0;
                sq_resolved[sq_head] <= 1'b0;
                sq_head              <= sq_head + 1'b1;
            end

            case ({sq_alloc, retire})
                2'b10:   sq_count <= sq_count + 1'b1;
                2'b01:   sq_count <= sq_count - 1'b1;
                default: sq_count <= sq_count;
            endcase
        end
    end

    // Address and data payload
    always_ff @(posedge clock) begin
        if (sq_resolve_valid) begin
            sq_entry_addr[sq_resolve_idx] <= sq_resolve_addr;
            sq_entry_data[sq_resolve_idx] <= sq_resolve_data;
        end
    end

    //////////////////////////////////////////////////
    // Environment checks
    //////////////////////////////////////////////////

    alloc_not_full: assert property (
        @(posedge clock) disable iff (reset)
        sq_alloc |-> !sq_full
    ) else $error("store allocated into a full queue");

    resolve_pending_slot: assert property (
        @(posedge clock) disable iff (reset)
        sq_resolve_valid |-> sq_busy[sq_resolve_idx] && !sq_resolved[sq_resolve_idx]
    ) else $error("store resolve names an empty or resolved slot");

endmodule
